//--- fog_loop_top.f
+incdir+.
fog_pkg.sv
fog_if.sv
mod_square_gen.sv
err_demod.sv
loop_integrator.sv
fog_channel.sv
dac_driver.sv
fog_loop_top.sv
fog_checker.sv
tb_fog_loop.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_fog_loop
FILELIST = fog_loop_top.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_fog_loop.sv
`default_nettype none

`include "fog_params.svh"

module tb_fog_loop import fog_pkg::*; ();

	localparam int NUM_TESTS = 8;
	localparam int RST_CYC = 10;
	localparam int MARGIN = 64; // slack on top of the summed test lengths
	localparam loop_word_t AMP_H = 32'sh0000_1234;
	localparam loop_word_t AMP_L = -32'sd5728;

	logic CLOCK_DAC_1;
	logic rst_n;
	half_cnt_t freq_cnt;
	half_cnt_t wait_cnt;
	avg_sel_t avg_sel;
	logic polarity;
	loop_word_t err_offset;
	gain_sel_t gain_sel;
	logic [`FOG_NUM_CH-1:0] fb_on;
	adc_sample_t adc [`FOG_NUM_CH];
	dac_code_t dac [`FOG_NUM_CH];
	logic dac_rst;
	int err_cnt;
	int chk_cnt;

	// test table
	string t_name [NUM_TESTS];
	half_cnt_t t_freq [NUM_TESTS];
	half_cnt_t t_wait [NUM_TESTS];
	avg_sel_t t_avg [NUM_TESTS];
	gain_sel_t t_gain [NUM_TESTS];
	logic t_pol [NUM_TESTS];
	loop_word_t t_off [NUM_TESTS];
	logic [`FOG_NUM_CH-1:0] t_fb [NUM_TESTS];
	logic t_rnd [NUM_TESTS]; // random ADC instead of per-half levels
	int t_periods [NUM_TESTS];

	half_cnt_t trk_pos; // own view of the modulation half
	logic trk_status;
	integer seed;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	fog_loop_top u_fog_loop_top (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (rst_n),
		.i_freq_cnt (freq_cnt),
		.i_amp_h (AMP_H),
		.i_amp_l (AMP_L),
		.i_wait_cnt (wait_cnt),
		.i_avg_sel (avg_sel),
		.i_polarity (polarity),
		.i_err_offset (err_offset),
		.i_gain_sel (gain_sel),
		.i_fb_on (fb_on),
		.i_adc (adc),
		.o_dac (dac),
		.o_dac_rst (dac_rst)
	);

	fog_checker u_fog_checker (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (rst_n),
		.i_freq_cnt (freq_cnt),
		.i_amp_h (AMP_H),
		.i_amp_l (AMP_L),
		.i_wait_cnt (wait_cnt),
		.i_avg_sel (avg_sel),
		.i_polarity (polarity),
		.i_err_offset (err_offset),
		.i_gain_sel (gain_sel),
		.i_fb_on (fb_on),
		.i_adc (adc),
		.i_dac (dac),
		.i_dac_rst (dac_rst),
		.o_err_cnt (err_cnt),
		.o_chk_cnt (chk_cnt)
	);

	always #2 CLOCK_DAC_1 = ~CLOCK_DAC_1; // period 4

	// half tracking so the constant levels follow the square wave
	always @(posedge CLOCK_DAC_1) begin
		if (!rst_n) begin
			trk_pos <= '0;
			trk_status <= 1'b0;
		end else if (trk_pos == half_cnt_t'(freq_cnt - 16'd1)) begin
			trk_pos <= '0;
			trk_status <= ~trk_status;
		end else begin
			trk_pos <= trk_pos + 16'd1;
		end
	end

	always @(posedge CLOCK_DAC_1) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic set_test(input int idx, input string name, input half_cnt_t freq,
		input half_cnt_t wt, input avg_sel_t avg, input gain_sel_t gain, input logic pol,
		input loop_word_t off, input logic [`FOG_NUM_CH-1:0] fb, input logic rnd,
		input int periods);
		t_name[idx] = name;
		t_freq[idx] = freq;
		t_wait[idx] = wt;
		t_avg[idx] = avg;
		t_gain[idx] = gain;
		t_pol[idx] = pol;
		t_off[idx] = off;
		t_fb[idx] = fb;
		t_rnd[idx] = rnd;
		t_periods[idx] = periods;
	endtask

	task automatic apply_config(input int t);
		freq_cnt = t_freq[t];
		wait_cnt = t_wait[t];
		avg_sel = t_avg[t];
		gain_sel = t_gain[t];
		polarity = t_pol[t];
		err_offset = t_off[t];
		fb_on = t_fb[t];
	endtask

	// distinct level per channel and half
	function automatic adc_sample_t const_level(input int ch, input logic high);
		int lvl;
		lvl = high ? 1500 + 211 * ch : -700 - 97 * ch;
		return adc_sample_t'(lvl);
	endfunction

	task automatic drive_adc(input int t);
		for (int ch = 0; ch < `FOG_NUM_CH; ch++) begin
			if (t_rnd[t])
				adc[ch] = adc_sample_t'($random(seed));
			else
				adc[ch] = const_level(ch, trk_status);
		end
	endtask

	initial begin
		int errs_before;
		seed = 32'h2835aa7f;
		CLOCK_DAC_1 = 1'b0;
		rst_n = 1'b0;
		set_test(0, "reset", 16'd8, 16'd0, 4'd0, 5'd0, 1'b0, 32'sd0, 3'b000, 1'b0, 2);
		set_test(1, "modulation", 16'd12, 16'd2, 4'd2, 5'd1, 1'b0, 32'sd0, 3'b000, 1'b0, 4);
		set_test(2, "avg0_gain2", 16'd16, 16'd3, 4'd0, 5'd2, 1'b0, 32'sd0, 3'b111, 1'b0, 6);
		set_test(3, "avg3_gain5", 16'd16, 16'd4, 4'd3, 5'd5, 1'b0, 32'sd0, 3'b111, 1'b0, 6);
		set_test(4, "avg8_gain2", 16'd270, 16'd10, 4'd8, 5'd2, 1'b0, 32'sd0, 3'b111, 1'b0, 3);
		set_test(5, "polarity", 16'd16, 16'd3, 4'd0, 5'd2, 1'b1, 32'sd0, 3'b111, 1'b0, 6);
		set_test(6, "offset", 16'd16, 16'd3, 4'd0, 5'd2, 1'b0, 32'sd1200, 3'b111, 1'b0, 6);
		set_test(7, "random_ch", 16'd20, 16'd2, 4'd4, 5'd3, 1'b0, 32'sd0, 3'b101, 1'b1, 6);
		apply_config(0);
		foreach (adc[ch])
			adc[ch] = '0;
		// reset, the periods themselves, one sync edge, per test
		for (int t = 0; t < NUM_TESTS; t++)
			cycle_limit += RST_CYC + 2 + 2 * int'(t_freq[t]) * t_periods[t];
		cycle_limit += MARGIN;

		for (int t = 0; t < NUM_TESTS; t++) begin
			errs_before = err_cnt;
			@(negedge CLOCK_DAC_1);
			rst_n = 1'b0; // config only changes under reset
			apply_config(t);
			drive_adc(t);
			repeat (RST_CYC - 1) begin
				@(negedge CLOCK_DAC_1);
				drive_adc(t);
			end
			@(negedge CLOCK_DAC_1);
			rst_n = 1'b1;
			drive_adc(t);
			repeat (2 * int'(t_freq[t]) * t_periods[t]) begin
				@(negedge CLOCK_DAC_1);
				drive_adc(t);
			end
			@(posedge CLOCK_DAC_1); // last compare has landed
			$display("test %0d %s: %0d mismatches, %s", t, t_name[t], err_cnt - errs_before,
				(err_cnt == errs_before) ? "ok" : "bad");
		end

		$display("tests %0d, checks %0d, mismatches %0d", NUM_TESTS, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- fog_checker.sv
`default_nettype none

`include "fog_params.svh"

module fog_checker import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	input wire half_cnt_t i_freq_cnt,
	input wire loop_word_t i_amp_h,
	input wire loop_word_t i_amp_l,
	input wire half_cnt_t i_wait_cnt,
	input wire avg_sel_t i_avg_sel,
	input wire logic i_polarity,
	input wire loop_word_t i_err_offset,
	input wire gain_sel_t i_gain_sel,
	input wire logic [`FOG_NUM_CH-1:0] i_fb_on,
	input wire adc_sample_t i_adc [`FOG_NUM_CH],
	input wire dac_code_t i_dac [`FOG_NUM_CH], // DUT outputs under test
	input wire logic i_dac_rst,
	output int o_err_cnt,
	output int o_chk_cnt
);

	// cycle model state, one copy of each loop register
	half_cnt_t m_pos;
	logic m_status;
	logic m_trig;
	loop_word_t m_acc [`FOG_NUM_CH]; // sum of the open half
	loop_word_t m_hi [`FOG_NUM_CH];
	loop_word_t m_lo [`FOG_NUM_CH];
	loop_word_t m_err [`FOG_NUM_CH];
	logic m_errv [`FOG_NUM_CH];
	loop_word_t m_step [`FOG_NUM_CH];
	loop_word_t m_ramp [`FOG_NUM_CH];
	dac_code_t m_dac [`FOG_NUM_CH];
	logic m_dac_rst;
	int cyc = 0; // clock edges seen
	int err_cnt = 0;
	int chk_cnt = 0;

	assign o_err_cnt = err_cnt;
	assign o_chk_cnt = chk_cnt;

	// one clock edge of the loop, everything read before it is overwritten
	function automatic void model_cycle();
		loop_word_t mod_lvl;
		loop_word_t fin_avg;
		loop_word_t diff;
		dac_code_t sum;
		logic in_win;
		int win_end;
		mod_lvl = m_status ? i_amp_h : i_amp_l;
		for (int ch = 0; ch < `FOG_NUM_CH; ch++) begin
			sum = dac_code_t'(m_ramp[ch] + mod_lvl); // low 16 bits only
			m_dac[ch] = {~sum[`FOG_DAC_W-1], sum[`FOG_DAC_W-2:0]}; // offset binary
		end
		m_dac_rst = !i_rst_n;
		if (!i_rst_n) begin
			m_pos = '0;
			m_status = 1'b0;
			m_trig = 1'b0;
			for (int ch = 0; ch < `FOG_NUM_CH; ch++) begin
				m_acc[ch] = '0;
				m_hi[ch] = '0;
				m_lo[ch] = '0;
				m_errv[ch] = 1'b0;
				m_step[ch] = '0;
				m_ramp[ch] = '0;
			end
		end else begin
			win_end = int'(i_wait_cnt) + (1 << i_avg_sel);
			in_win = (int'(m_pos) >= int'(i_wait_cnt)) && (int'(m_pos) < win_end);
			for (int ch = 0; ch < `FOG_NUM_CH; ch++) begin
				// feedback acts on the error strobed this cycle
				if (m_errv[ch]) begin
					if (i_fb_on[ch]) begin
						m_step[ch] = m_step[ch] + (m_err[ch] >>> i_gain_sel);
						m_ramp[ch] = m_ramp[ch] + m_step[ch]; // new step goes in
					end else begin
						m_step[ch] = '0;
					end
				end
				m_errv[ch] = m_trig && !m_status; // positive half just closed
				if (m_trig) begin
					fin_avg = m_acc[ch] >>> i_avg_sel;
					if (m_status) begin
						m_lo[ch] = fin_avg; // closed half was negative
					end else begin
						m_hi[ch] = fin_avg;
						diff = m_hi[ch] - m_lo[ch];
						m_err[ch] = (i_polarity ? -diff : diff) + i_err_offset;
					end
					m_acc[ch] = '0;
				end
				if (in_win)
					m_acc[ch] = m_acc[ch] + loop_word_t'(i_adc[ch]); // sign extended
			end
			// half period position and boundary pulse
			m_trig = (m_pos == half_cnt_t'(i_freq_cnt - 16'd1));
			if (m_trig) begin
				m_pos = '0;
				m_status = ~m_status;
			end else begin
				m_pos = m_pos + 16'd1;
			end
		end
	endfunction

	always @(posedge CLOCK_DAC_1) begin
		model_cycle();
		cyc = cyc + 1;
	end

	// outputs settle after the rising edge, compare mid cycle
	always @(negedge CLOCK_DAC_1) begin
		if (cyc >= 1) begin
			chk_cnt++;
			if (i_dac_rst !== m_dac_rst) begin
				err_cnt++;
				$display("MISMATCH o_dac_rst cycle %0d: expected %h, got %h",
					cyc, m_dac_rst, i_dac_rst);
			end
		end
		if (cyc >= 2) begin // DAC register holds X until reset has passed through
			for (int ch = 0; ch < `FOG_NUM_CH; ch++) begin
				chk_cnt++;
				if (i_dac[ch] !== m_dac[ch]) begin
					err_cnt++;
					$display("MISMATCH o_dac[%0d] cycle %0d: expected %h, got %h",
						ch, cyc, m_dac[ch], i_dac[ch]);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- fog_loop_top.sv
`default_nettype none

`include "fog_params.svh"

module fog_loop_top import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	// modulation setup
	input wire half_cnt_t i_freq_cnt,
	input wire loop_word_t i_amp_h,
	input wire loop_word_t i_amp_l,
	// demodulator setup, common to all channels
	input wire half_cnt_t i_wait_cnt,
	input wire avg_sel_t i_avg_sel,
	input wire logic i_polarity,
	input wire loop_word_t i_err_offset,
	// feedback setup
	input wire gain_sel_t i_gain_sel,
	input wire logic [`FOG_NUM_CH-1:0] i_fb_on, // one enable per channel
	// converters
	input wire adc_sample_t i_adc [`FOG_NUM_CH],
	output dac_code_t o_dac [`FOG_NUM_CH],
	output logic o_dac_rst
);

	mod_if u_mod_if (); // shared square wave timing
	dac_code_t ramp [`FOG_NUM_CH]; // per-channel ramps gathered for the driver

	mod_square_gen u_mod_square_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (i_rst_n),
		.i_freq_cnt (i_freq_cnt),
		.i_amp_h (i_amp_h),
		.i_amp_l (i_amp_l),
		.o_mod (u_mod_if.source)
	);

	// identical loops, all locked to the one modulation
	for (genvar ch = 0; ch < `FOG_NUM_CH; ch++) begin : g_ch
		fog_channel u_fog_channel (
			.CLOCK_DAC_1 (CLOCK_DAC_1),
			.i_rst_n (i_rst_n),
			.i_adc (i_adc[ch]),
			.i_wait_cnt (i_wait_cnt),
			.i_avg_sel (i_avg_sel),
			.i_polarity (i_polarity),
			.i_err_offset (i_err_offset),
			.i_fb_on (i_fb_on[ch]),
			.i_gain_sel (i_gain_sel),
			.i_mod (u_mod_if.sink),
			.o_ramp (ramp[ch])
		);
	end

	dac_driver u_dac_driver (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (i_rst_n),
		.i_mod (u_mod_if.sink),
		.i_ramp (ramp),
		.o_dac (o_dac),
		.o_dac_rst (o_dac_rst)
	);

endmodule

`default_nettype wire

//--- dac_driver.sv
`default_nettype none

`include "fog_params.svh"

module dac_driver import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	mod_if.sink i_mod, // modulation added on top of every ramp
	input wire dac_code_t i_ramp [`FOG_NUM_CH],
	output dac_code_t o_dac [`FOG_NUM_CH], // offset binary
	output logic o_dac_rst
);

	dac_code_t dac_sum [`FOG_NUM_CH]; // two's complement ramp + mod
	logic dac_rst_q;

	// only the low bits matter, so add at DAC width
	always_comb begin
		for (int ch = 0; ch < `FOG_NUM_CH; ch++)
			dac_sum[ch] = i_ramp[ch] + dac_code_t'(i_mod.mod_out);
	end

	// output registers, msb flip turns signed into offset binary
	always_ff @(posedge CLOCK_DAC_1) begin
		for (int ch = 0; ch < `FOG_NUM_CH; ch++)
			o_dac[ch] <= {~dac_sum[ch][`FOG_DAC_W-1], dac_sum[ch][`FOG_DAC_W-2:0]};
	end

	// DAC reset held through reset, drops one cycle after release
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n)
			dac_rst_q <= 1'b1;
		else
			dac_rst_q <= 1'b0;
	end

	assign o_dac_rst = dac_rst_q;

endmodule

`default_nettype wire

//--- fog_channel.sv
`default_nettype none

module fog_channel import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	input wire adc_sample_t i_adc,
	input wire half_cnt_t i_wait_cnt,
	input wire avg_sel_t i_avg_sel,
	input wire logic i_polarity,
	input wire loop_word_t i_err_offset,
	input wire logic i_fb_on,
	input wire gain_sel_t i_gain_sel,
	mod_if.sink i_mod, // shared modulation timing
	output dac_code_t o_ramp
);

	err_if u_err_if (); // demodulator to integrator, private to this channel

	// demodulate, one error per modulation period
	err_demod u_err_demod (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (i_rst_n),
		.i_adc (i_adc),
		.i_wait_cnt (i_wait_cnt),
		.i_avg_sel (i_avg_sel),
		.i_polarity (i_polarity),
		.i_err_offset (i_err_offset),
		.i_mod (i_mod),
		.o_err (u_err_if.source)
	);

	// error -> step -> ramp
	loop_integrator u_loop_integrator (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst_n (i_rst_n),
		.i_fb_on (i_fb_on),
		.i_gain_sel (i_gain_sel),
		.i_err (u_err_if.sink),
		.o_ramp (o_ramp)
	);

endmodule

`default_nettype wire

//--- loop_integrator.sv
`default_nettype none

module loop_integrator import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	input wire logic i_fb_on, // closes the loop for this channel
	input wire gain_sel_t i_gain_sel, // feedback gain as a right shift
	err_if.sink i_err,
	output dac_code_t o_ramp // phase ramp toward the DAC
);

	loop_word_t step; // feedback step, integral of err
	loop_word_t ramp; // phase ramp, integral of step
	loop_word_t step_next;

	// scaled error added to the held step
	assign step_next = step + (i_err.err >>> i_gain_sel);

	// both integrators advance once per period, on err_valid
	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			step <= '0;
			ramp <= '0;
		end else if (i_err.err_valid) begin
			if (i_fb_on) begin
				step <= step_next;
				ramp <= ramp + step_next; // uses the new step, wraps at 32 bits
			end else begin
				step <= '0; // open loop, ramp parks where it is
			end
		end
	end

	// DAC only sees the low bits, the 2pi reset is the natural wrap
	assign o_ramp = dac_code_t'(ramp);

endmodule

`default_nettype wire

//--- err_demod.sv
`default_nettype none

`include "fog_params.svh"

module err_demod import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	input wire adc_sample_t i_adc, // photodetector samples
	input wire half_cnt_t i_wait_cnt, // settle cycles before the window
	input wire avg_sel_t i_avg_sel, // window is 2**avg_sel samples
	input wire logic i_polarity, // flip error sign
	input wire loop_word_t i_err_offset, // added after the sign flip
	mod_if.sink i_mod,
	err_if.source o_err
);

	loop_word_t sample; // sign extended ADC sample
	loop_word_t acc; // running sum of the current half
	loop_word_t half_avg; // average of the half that just closed
	loop_word_t high_avg;
	loop_word_t low_avg;
	loop_word_t diff; // high minus low
	loop_word_t err;
	logic err_valid;
	logic [`FOG_CNT_W:0] win_len; // one bit wider, no overflow
	logic [`FOG_CNT_W:0] win_end;
	logic in_win; // this cycle is inside the settle window
	logic high_done; // boundary closing a positive half

	assign sample = loop_word_t'(i_adc);

	// window is [wait_cnt, wait_cnt + 2**avg_sel)
	assign win_len = {{`FOG_CNT_W{1'b0}}, 1'b1} << i_avg_sel;
	assign win_end = {1'b0, i_wait_cnt} + win_len;
	assign in_win = (i_mod.half_pos >= i_wait_cnt) && ({1'b0, i_mod.half_pos} < win_end);

	// power of two average, arithmetic shift keeps the sign
	assign half_avg = acc >>> i_avg_sel;

	// status has already flipped when step_trig shows up
	assign high_done = i_mod.step_trig && !i_mod.status;

	// new high average goes straight into the difference
	assign diff = half_avg - low_avg;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			acc <= '0;
			high_avg <= '0;
			low_avg <= '0;
			err_valid <= 1'b0;
		end else begin
			err_valid <= high_done; // one cycle after the boundary
			if (i_mod.step_trig) begin
				// position 0 may already be in the next window
				acc <= in_win ? sample : '0;
				if (i_mod.status)
					low_avg <= half_avg; // negative half just ended
				else
					high_avg <= half_avg;
			end else if (in_win) begin
				acc <= acc + sample;
			end
		end
	end

	// error word, only meaningful while err_valid is high
	always_ff @(posedge CLOCK_DAC_1) begin
		if (high_done)
			err <= (i_polarity ? -diff : diff) + i_err_offset;
	end

	assign o_err.err = err;
	assign o_err.err_valid = err_valid;
	assign o_err.high_avg = high_avg;
	assign o_err.low_avg = low_avg;

endmodule

`default_nettype wire

//--- mod_square_gen.sv
`default_nettype none

module mod_square_gen import fog_pkg::*; (
	input wire logic CLOCK_DAC_1,
	input wire logic i_rst_n,
	input wire half_cnt_t i_freq_cnt, // cycles per half
	input wire loop_word_t i_amp_h, // level in positive half
	input wire loop_word_t i_amp_l, // level in negative half
	mod_if.source o_mod
);

	half_cnt_t half_pos; // runs 0 .. freq_cnt-1
	logic status; // current half, starts low
	logic step_trig; // registered boundary pulse
	logic last_pos; // final cycle of this half

	// compare against freq_cnt-1 so the wrap costs no extra cycle
	assign last_pos = (half_pos == half_cnt_t'(i_freq_cnt - 1'b1));

	always_ff @(posedge CLOCK_DAC_1) begin
		if (!i_rst_n) begin
			half_pos <= '0;
			status <= 1'b0; // negative half first
			step_trig <= 1'b0;
		end else begin
			step_trig <= last_pos; // lands on position 0 of the new half
			if (last_pos) begin
				half_pos <= '0;
				status <= ~status; // flip half
			end else begin
				half_pos <= half_pos + 1'b1;
			end
		end
	end

	// amplitude follows status with no extra register
	assign o_mod.mod_out = status ? i_amp_h : i_amp_l;
	assign o_mod.status = status;
	assign o_mod.step_trig = step_trig;
	assign o_mod.half_pos = half_pos; // shared by every channel window

endmodule

`default_nettype wire

//--- fog_if.sv
`default_nettype none

// modulation bus, one generator fans out to all channels and the DAC driver
interface mod_if import fog_pkg::*; ();

	loop_word_t mod_out; // amp_h or amp_l
	logic status; // 1 in the positive half
	logic step_trig; // first cycle of each new half
	half_cnt_t half_pos; // cycle index inside the half

	modport source (
		output mod_out,
		output status,
		output step_trig,
		output half_pos
	);

	modport sink (
		input mod_out,
		input status,
		input step_trig,
		input half_pos
	);

endinterface

// per-channel demodulator result, err qualified by err_valid
interface err_if import fog_pkg::*; ();

	loop_word_t err;
	logic err_valid; // single cycle strobe per period
	loop_word_t high_avg; // monitor only
	loop_word_t low_avg; // monitor only

	modport source (output err, output err_valid, output high_avg, output low_avg);

	modport sink (input err, input err_valid, input high_avg, input low_avg);

endinterface

`default_nettype wire

//--- fog_pkg.sv
`default_nettype none

`include "fog_params.svh"

package fog_pkg;

	// raw ADC stream, two's complement
	typedef logic signed [`FOG_ADC_W-1:0] adc_sample_t;

	// DAC code, offset binary at the pins
	typedef logic [`FOG_DAC_W-1:0] dac_code_t;

	// loop arithmetic word, wraps freely
	typedef logic signed [`FOG_WORD_W-1:0] loop_word_t;

	// position inside a modulation half
	typedef logic [`FOG_CNT_W-1:0] half_cnt_t;

	// averaging shift, sized to hold 0..FOG_AVG_MAX
	typedef logic [$clog2(`FOG_AVG_MAX+1)-1:0] avg_sel_t;

	// feedback gain shift, any shift of the loop word
	typedef logic [$clog2(`FOG_WORD_W)-1:0] gain_sel_t;

endpackage

`default_nettype wire

//--- fog_params.svh
`ifndef FOG_PARAMS_SVH
`define FOG_PARAMS_SVH

// loop channel count, one ADC in and one DAC out each
`define FOG_NUM_CH 3

// converter widths
`define FOG_ADC_W 14 // signed ADC sample
`define FOG_DAC_W 16 // parallel DAC code

// internal loop arithmetic
`define FOG_WORD_W 32 // err, step, ramp, amplitudes, offset

// modulation half-period counter, also the settle wait
`define FOG_CNT_W 16

// largest averaging shift, window is 2**avg_sel samples
// 8 gives 256 samples per half, well inside FOG_WORD_W
`define FOG_AVG_MAX 8

`endif
